/* Makefile */
# Verilator build and run of the operand queue testbench

SIM  = obj_dir/Vtb_operand_queue
SRCS = list.f $(wildcard verilog/*.sv verilog/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_operand_queue

run: $(SIM)
	./$(SIM) +verilator+error+limit+100 | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* list.f */
+incdir+verilog
verilog/opq_pkg.sv
verilog/opq_fifo.sv
verilog/opq_operand_buffer.sv
verilog/opq_widen.sv
verilog/opq_issue_ctrl.sv
verilog/operand_queue.sv
testbench/tb_clock_gen.sv
testbench/operand_queue_assert.sv
testbench/tb_operand_queue.sv

/* testbench/operand_queue_assert.sv */
// Port-level protocol checks of the operand queue
// Bound to operand_queue from the testbench, failures also counted in the testbench
`timescale 1ns/1ns

module operand_queue_assert import opq_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       flush_i,
  input logic       operand_issued_i,
  input logic       operand_ready_o,
  input logic       operand_valid_o,
  input elen_t      operand_o,
  input target_fu_e operand_target_fu_o,
  input slave_rdy_t operand_ready_i
);

  // Idle right out of reset
  a_reset_idle: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (!operand_valid_o && operand_ready_o))
    else begin
      $error("Queue not idle after reset");
      tb_operand_queue.sva_errors = tb_operand_queue.sva_errors + 1;
    end

  // Register file may only announce a word while a credit is free
  a_issue_with_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    operand_issued_i |-> operand_ready_o)
    else begin
      $error("Operand issued while operand_ready_o was low");
      tb_operand_queue.sva_errors = tb_operand_queue.sva_errors + 1;
    end

  // Stalled beat keeps its word and target
  a_hold_on_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (operand_valid_o && !(|operand_ready_i) && !flush_i)
      |=> (operand_valid_o && $stable(operand_o) && $stable(operand_target_fu_o)))
    else begin
      $error("Output changed under back-pressure");
      tb_operand_queue.sva_errors = tb_operand_queue.sva_errors + 1;
    end

  // Flush leaves an empty queue with all credits back
  a_flush_empties: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> (!operand_valid_o && operand_ready_o))
    else begin
      $error("Queue not empty after flush");
      tb_operand_queue.sva_errors = tb_operand_queue.sva_errors + 1;
    end

endmodule

/* testbench/tb_clock_gen.sv */
// Clock and reset source for the operand queue testbench
// 20 ns clock, reset held low for 10 cycles and released on a falling edge
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

  always #10 clk_o = ~clk_o;

endmodule

/* testbench/tb_operand_queue.sv */
// Testbench of the operand queue: random commands and register file words,
// a queue model of the widened output stream, checks on every output beat
`timescale 1ns/1ns
`include "opq_cfg.svh"

module tb_operand_queue import opq_pkg::*; ();

  localparam int unsigned WaitLimit = 5000;

  typedef struct packed {
    elen_t      word;
    target_fu_e fu;
    logic       last;
  } beat_t;

  logic       clk;
  logic       rst_n;
  logic       flush;
  opq_cmd_t   cmd;
  logic       cmd_valid;
  elen_t      rf_word;
  logic       rf_valid;
  logic       rf_issued;
  logic       rf_ready;
  elen_t      fu_word;
  target_fu_e fu_target;
  logic       fu_valid;
  slave_rdy_t fu_ready;

  beat_t exp_q[$];
  beat_t exp_beat;
  bit    consume_en;
  bit    last_seen;
  int    cmds_pushed;
  int    cmds_done;
  int    check_errors;
  int    timeout_errors;
  int    sva_errors;

  tb_clock_gen i_clock_gen (
    .clk_o  (clk  ),
    .rst_no (rst_n)
  );

  operand_queue i_operand_queue (
    .clk_i               (clk      ),
    .rst_ni              (rst_n    ),
    .flush_i             (flush    ),
    .cmd_i               (cmd      ),
    .cmd_valid_i         (cmd_valid),
    .operand_i           (rf_word  ),
    .operand_valid_i     (rf_valid ),
    .operand_issued_i    (rf_issued),
    .operand_ready_o     (rf_ready ),
    .operand_o           (fu_word  ),
    .operand_target_fu_o (fu_target),
    .operand_valid_o     (fu_valid ),
    .operand_ready_i     (fu_ready )
  );

  bind operand_queue operand_queue_assert i_operand_queue_assert (
    .clk_i               (clk_i              ),
    .rst_ni              (rst_ni             ),
    .flush_i             (flush_i            ),
    .operand_issued_i    (operand_issued_i   ),
    .operand_ready_o     (operand_ready_o    ),
    .operand_valid_o     (operand_valid_o    ),
    .operand_o           (operand_o          ),
    .operand_target_fu_o (operand_target_fu_o),
    .operand_ready_i     (operand_ready_i    )
  );

  ////////////////////////////////////////////////////////////
  // Reference model of the widening
  ////////////////////////////////////////////////////////////

  function automatic int factor_of(conv_e c);
    case (c)
      CONV_SEXT2, CONV_ZEXT2: return 2;
      CONV_SEXT4, CONV_ZEXT4: return 4;
      CONV_SEXT8, CONV_ZEXT8: return 8;
      default:                return 1;
    endcase
  endfunction

  // Elements of ew bits from the slice at byte sel, each grown to ew*f bits
  function automatic elen_t widen_ref(elen_t w, int sel, int ew, int f, bit sx);
    elen_t slice;
    elen_t res;
    elen_t e;
    elen_t in_mask;
    elen_t out_mask;
    slice    = w >> (8 * sel);
    in_mask  = (ew == 64) ? '1 : (64'd1 << ew) - 64'd1;
    out_mask = (ew * f == 64) ? '1 : (64'd1 << (ew * f)) - 64'd1;
    res      = '0;
    for (int i = 0; i < 64 / (ew * f); i++) begin
      e = (slice >> (i * ew)) & in_mask;
      if (sx && e[ew-1]) e = e | ~in_mask;
      res = res | ((e & out_mask) << (i * ew * f));
    end
    return res;
  endfunction

  // Up to three words worth of elements
  function automatic int pick_count(eew_e e);
    return 1 + int'($urandom % (3 * (8 >> e)));
  endfunction

  ////////////////////////////////////////////////////////////
  // Bounded waits
  ////////////////////////////////////////////////////////////

  task automatic wait_ready();
    int n;
    n = 0;
    @(negedge clk);
    while (!rf_ready && n < WaitLimit) begin
      @(negedge clk);
      n++;
    end
    if (!rf_ready) begin
      $display("Timeout at %0t waiting for operand_ready_o", $time);
      timeout_errors++;
    end
  endtask

  task automatic wait_cmd_slot();
    int n;
    n = 0;
    @(negedge clk);
    while (cmds_pushed - cmds_done >= `OPQ_CMD_DEPTH && n < WaitLimit) begin
      @(negedge clk);
      n++;
    end
    if (cmds_pushed - cmds_done >= `OPQ_CMD_DEPTH) begin
      $display("Timeout at %0t waiting for a free command slot", $time);
      timeout_errors++;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || cmds_done != cmds_pushed) && n < WaitLimit) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0 || cmds_done != cmds_pushed) begin
      $display("Timeout at %0t with %0d beats still expected", $time, exp_q.size());
      timeout_errors++;
    end
  endtask

  // Consumer enable changes on the rising edge, away from the sampling edge
  task automatic set_consume(input bit en);
    @(posedge clk);
    consume_en = en;
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic send_word(input elen_t w);
    wait_ready();
    rf_issued = 1'b1;
    @(negedge clk);
    rf_issued = 1'b0;
    rf_valid  = 1'b1;
    rf_word   = w;
    @(negedge clk);
    rf_valid  = 1'b0;
  endtask

  task automatic run_command(input conv_e conv, input eew_e eew, input target_fu_e fu,
                             input int count);
    elen_t words[$];
    beat_t b;
    int    ew;
    int    f;
    int    step;
    int    elems;
    int    sel;
    bit    widen;
    bit    sx;
    ew    = 8 << eew;
    f     = factor_of(conv);
    widen = (f > 1) && (ew * f <= 64);
    sx    = conv inside {CONV_SEXT2, CONV_SEXT4, CONV_SEXT8};
    // Unsupported pairs get one element, so one pass-through beat
    if (f > 1 && !widen) count = 1;
    step  = widen ? (64 / ew) / f : 64 / ew;
    words.push_back({$urandom, $urandom});
    elems = 0;
    sel   = 0;
    while (elems < count) begin
      b.word = widen ? widen_ref(words[$], sel, ew, f, sx) : words[$];
      b.fu   = fu;
      elems  = elems + step;
      sel    = (sel + 8 / f) % 8;
      b.last = (elems >= count);
      exp_q.push_back(b);
      if (!b.last && (f == 1 || sel == 0)) words.push_back({$urandom, $urandom});
    end
    wait_cmd_slot();
    cmd.conv       = conv;
    cmd.eew        = eew;
    cmd.elem_count = elem_cnt_t'(count);
    cmd.target_fu  = fu;
    cmd_valid      = 1'b1;
    cmds_pushed++;
    @(negedge clk);
    cmd_valid = 1'b0;
    foreach (words[i]) send_word(words[i]);
  endtask

  task automatic run_random(input int num);
    eew_e e;
    repeat (num) begin
      e = eew_e'($urandom % 4);
      run_command(conv_e'($urandom % 7), e, target_fu_e'($urandom % 2), pick_count(e));
    end
  endtask

  // Fills every credit with the consumer stalled
  task automatic hold_full_buffer();
    set_consume(1'b0);
    run_command(CONV_NONE, EW64, FU_MFPU_ADDRGEN, `OPQ_DATA_DEPTH);
    assert (!rf_ready && fu_valid) else begin
      $display("Ready still high or no valid output with all credits taken");
      check_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Output checking, sampled on the falling edge
  ////////////////////////////////////////////////////////////

  task automatic check_beat();
    if (exp_q.size() == 0) begin
      $display("Output beat at %0t with no operand expected", $time);
      check_errors++;
    end else begin
      exp_beat = exp_q.pop_front();
      assert (fu_word === exp_beat.word) else begin
        $display("FAILED t=%0t operand_o expected %h actual %h",
                 $time, exp_beat.word, fu_word);
        check_errors++;
      end
      assert (fu_target === exp_beat.fu) else begin
        $display("FAILED t=%0t operand_target_fu_o expected %0d actual %0d",
                 $time, exp_beat.fu, fu_target);
        check_errors++;
      end
      last_seen = exp_beat.last;
    end
  endtask

  always @(negedge clk) begin
    // A command counts as done one cycle after its last beat
    cmds_done = cmds_done + int'(last_seen);
    last_seen = 1'b0;
    // Head word and ready seen here are what the next rising edge transfers
    fu_ready = consume_en ? slave_rdy_t'($urandom) : '0;
    if (rst_n && fu_valid && (|fu_ready)) check_beat();
  end

  initial begin
    int n;
    void'($urandom(32'h2907));
    flush      = 1'b0;
    cmd        = '0;
    cmd_valid  = 1'b0;
    rf_word    = '0;
    rf_valid   = 1'b0;
    rf_issued  = 1'b0;
    fu_ready   = '0;
    consume_en = 1'b1;
    n = 0;
    while (!rst_n && n < WaitLimit) begin
      @(negedge clk);
      n++;
    end
    if (!rst_n) begin
      $display("Timeout waiting for reset release");
      timeout_errors++;
    end

    // Every conversion and width pair once
    for (int c = 0; c < 7; c++) begin
      for (int e = 0; e < 4; e++) begin
        run_command(conv_e'(c), eew_e'(e), target_fu_e'($urandom % 2), pick_count(eew_e'(e)));
      end
    end
    run_random(40);
    wait_drain();

    // Credits run out, then return with the first pop
    hold_full_buffer();
    set_consume(1'b1);
    wait_ready();
    wait_drain();

    // Flush a full buffer
    hold_full_buffer();
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    assert (!fu_valid && rf_ready) else begin
      $display("Valid still high or ready still low after flush");
      check_errors++;
    end
    exp_q.delete();
    cmds_pushed = cmds_done;
    set_consume(1'b1);
    run_random(12);
    wait_drain();
    assert (!fu_valid) else begin
      $display("Output still valid after all expected beats");
      check_errors++;
    end

    $display("Errors: %0d check, %0d timeout, %0d assertion",
             check_errors, timeout_errors, sva_errors);
    if (check_errors + timeout_errors + sva_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* verilog/operand_queue.sv */
// Vector-lane operand queue top level
// Buffers commands and register file words, widens them and hands them to the FUs
`timescale 1ns/1ns
`include "opq_cfg.svh"

module operand_queue import opq_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       flush_i,
  // Operand requester
  input  opq_cmd_t   cmd_i,
  input  logic       cmd_valid_i,
  // Register file
  input  elen_t      operand_i,
  input  logic       operand_valid_i,
  input  logic       operand_issued_i,
  output logic       operand_ready_o,
  // Functional units
  output elen_t      operand_o,
  output target_fu_e operand_target_fu_o,
  output logic       operand_valid_o,
  input  slave_rdy_t operand_ready_i
);

  opq_cmd_t  head_cmd;
  logic      cmd_empty;
  logic      cmd_pop;
  elen_t     head_word;
  logic      word_present;
  logic      word_pop;
  byte_sel_t sel;

  opq_fifo #(
    .DEPTH (`OPQ_CMD_DEPTH),
    .dtype (opq_cmd_t     )
  ) i_cmd_buffer (
    .clk_i   (clk_i      ),
    .rst_ni  (rst_ni     ),
    .flush_i (flush_i    ),
    .push_i  (cmd_valid_i),
    .data_i  (cmd_i      ),
    .pop_i   (cmd_pop    ),
    .data_o  (head_cmd   ),
    .empty_o (cmd_empty  ),
    .full_o  (           )
  );

  opq_operand_buffer i_operand_buffer (
    .clk_i            (clk_i           ),
    .rst_ni           (rst_ni          ),
    .flush_i          (flush_i         ),
    .operand_valid_i  (operand_valid_i ),
    .operand_i        (operand_i       ),
    .operand_issued_i (operand_issued_i),
    .pop_i            (word_pop        ),
    .head_o           (head_word       ),
    .present_o        (word_present    ),
    .operand_ready_o  (operand_ready_o )
  );

  opq_widen i_widen (
    .word_i (head_word),
    .cmd_i  (head_cmd ),
    .sel_i  (sel      ),
    .word_o (operand_o)
  );

  opq_issue_ctrl i_issue_ctrl (
    .clk_i           (clk_i          ),
    .rst_ni          (rst_ni         ),
    .flush_i         (flush_i        ),
    .cmd_i           (head_cmd       ),
    .word_present_i  (word_present   ),
    .cmd_present_i   (!cmd_empty     ),
    .operand_ready_i (operand_ready_i),
    .sel_o           (sel            ),
    .operand_valid_o (operand_valid_o),
    .word_pop_o      (word_pop       ),
    .cmd_pop_o       (cmd_pop        )
  );

  // Target FU comes straight from the head command
  assign operand_target_fu_o = head_cmd.target_fu;

endmodule

/* verilog/opq_cfg.svh */
// Build-time sizes of the vector-lane operand queue
// Included by the package and by every module that sizes a buffer
`ifndef OPQ_CFG_SVH
`define OPQ_CFG_SVH

// Operand word width in bits
`define OPQ_ELEN 64

// Vector length in bits, bounds the element count of a command
`define OPQ_VLEN 1024

// Command buffer depth
`define OPQ_CMD_DEPTH 2

// Operand buffer depth, also the number of credits toward the register file
`define OPQ_DATA_DEPTH 2

// Number of consumer ready lines
`define OPQ_NR_SLAVES 2

`endif

/* verilog/opq_fifo.sv */
// Synchronous circular FIFO with flush, head word visible on data_o
// Used for both the command buffer and the operand buffer
`timescale 1ns/1ns

module opq_fifo #(
  parameter int unsigned DEPTH = 2,
  parameter type         dtype = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic flush_i,
  input  logic push_i,
  input  dtype data_i,
  input  logic pop_i,
  output dtype data_o,
  output logic empty_o,
  output logic full_o
);

  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CntW = $clog2(DEPTH + 1);

  dtype            mem_q [DEPTH];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_push, do_pop;

  // Pointer increment with wrap at DEPTH
  function automatic logic [PtrW-1:0] next_ptr(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CntW'(DEPTH));
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      count_q <= count_q + CntW'(do_push) - CntW'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

/* verilog/opq_issue_ctrl.sv */
// Output side of the operand queue: beat detection, select pointer, element count
// Decides when the head word and the head command are used up
`timescale 1ns/1ns

module opq_issue_ctrl import opq_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       flush_i,
  input  opq_cmd_t   cmd_i,
  input  logic       word_present_i,
  input  logic       cmd_present_i,
  input  slave_rdy_t operand_ready_i,
  output byte_sel_t  sel_o,
  output logic       operand_valid_o,
  output logic       word_pop_o,
  output logic       cmd_pop_o
);

  localparam int unsigned WordBytes = $bits(elen_t) / 8;

  byte_sel_t  select_d, select_q;
  elem_cnt_t  elem_count_d, elem_count_q;
  logic       transfer;
  logic [1:0] lg_factor;
  byte_sel_t  sel_step;
  elem_cnt_t  elem_step;

  // log2 of the widening factor, 0 means no widening
  always_comb begin
    case (cmd_i.conv)
      CONV_SEXT2, CONV_ZEXT2: lg_factor = 2'd1;
      CONV_SEXT4, CONV_ZEXT4: lg_factor = 2'd2;
      CONV_SEXT8, CONV_ZEXT8: lg_factor = 2'd3;
      default:                lg_factor = 2'd0;
    endcase
  end

  // Bytes and elements consumed per beat
  always_comb begin
    sel_step  = (lg_factor == 2'd0) ? '0 : byte_sel_t'(WordBytes >> lg_factor);
    elem_step = elem_cnt_t'((WordBytes >> cmd_i.eew) >> lg_factor);
    // Unsupported pairs still retire one element per beat
    if (elem_step == '0) elem_step = elem_cnt_t'(1);
  end

  assign operand_valid_o = word_present_i & cmd_present_i;
  assign transfer        = operand_valid_o & (|operand_ready_i);
  assign sel_o           = select_q;

  ////////////////////////////////////////////////////////////
  // Counter update and pops
  ////////////////////////////////////////////////////////////

  always_comb begin
    select_d     = select_q;
    elem_count_d = elem_count_q;
    word_pop_o   = 1'b0;
    cmd_pop_o    = 1'b0;
    if (transfer) begin
      select_d     = select_q + sel_step;
      elem_count_d = elem_count_q + elem_step;
      // Word is used up once select wraps back to byte 0
      if ((select_q != '0 && select_d == '0) || lg_factor == 2'd0) word_pop_o = 1'b1;
      if (elem_count_d >= cmd_i.elem_count) begin
        word_pop_o   = 1'b1;
        cmd_pop_o    = 1'b1;
        select_d     = '0;
        elem_count_d = '0;
      end
    end
    if (flush_i) begin
      select_d     = '0;
      elem_count_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      select_q     <= '0;
      elem_count_q <= '0;
    end else begin
      select_q     <= select_d;
      elem_count_q <= elem_count_d;
    end
  end

endmodule

/* verilog/opq_operand_buffer.sv */
// Input side of the operand queue: operand FIFO plus credit counter
// The credits drive operand_ready_o so the register file never overflows the FIFO
`timescale 1ns/1ns
`include "opq_cfg.svh"

module opq_operand_buffer import opq_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  flush_i,
  input  logic  operand_valid_i,
  input  elen_t operand_i,
  input  logic  operand_issued_i,
  input  logic  pop_i,
  output elen_t head_o,
  output logic  present_o,
  output logic  operand_ready_o
);

  localparam int unsigned Depth = `OPQ_DATA_DEPTH;
  localparam int unsigned CntW  = $clog2(Depth + 1);

  logic            empty;
  logic [CntW-1:0] credit_d, credit_q;

  opq_fifo #(
    .DEPTH (Depth ),
    .dtype (elen_t)
  ) i_operand_fifo (
    .clk_i   (clk_i          ),
    .rst_ni  (rst_ni         ),
    .flush_i (flush_i        ),
    .push_i  (operand_valid_i),
    .data_i  (operand_i      ),
    .pop_i   (pop_i          ),
    .data_o  (head_o         ),
    .empty_o (empty          ),
    .full_o  (               )
  );

  assign present_o = ~empty;

  ////////////////////////////////////////////////////////////
  // Credits: one per announced word, returned on pop
  ////////////////////////////////////////////////////////////

  always_comb begin
    credit_d = credit_q + CntW'(operand_issued_i) - CntW'(pop_i);
    if (flush_i) credit_d = '0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= '0;
    end else begin
      credit_q <= credit_d;
    end
  end

  assign operand_ready_o = (credit_q < CntW'(Depth));

endmodule

/* verilog/opq_pkg.sv */
// Shared types of the operand queue: word and count vectors, encodings, command
// Compile before any module of the queue
`include "opq_cfg.svh"

package opq_pkg;

  typedef logic [`OPQ_ELEN-1:0]              elen_t;
  typedef logic [$clog2(`OPQ_VLEN+1)-1:0]    elem_cnt_t;
  typedef logic [$clog2(`OPQ_ELEN/8)-1:0]    byte_sel_t;
  typedef logic [`OPQ_NR_SLAVES-1:0]         slave_rdy_t;

  // Element width
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } eew_e;

  // Integer widening applied on the way out
  typedef enum logic [2:0] {
    CONV_NONE  = 3'd0,
    CONV_SEXT2 = 3'd1,
    CONV_SEXT4 = 3'd2,
    CONV_SEXT8 = 3'd3,
    CONV_ZEXT2 = 3'd4,
    CONV_ZEXT4 = 3'd5,
    CONV_ZEXT8 = 3'd6
  } conv_e;

  typedef enum logic {
    FU_ALU_SLDU     = 1'b0,
    FU_MFPU_ADDRGEN = 1'b1
  } target_fu_e;

  typedef struct packed {
    conv_e      conv;
    eew_e       eew;
    elem_cnt_t  elem_count;
    target_fu_e target_fu;
  } opq_cmd_t;

endpackage

/* verilog/opq_widen.sv */
// Integer widening of the head operand word, purely combinational
// Extends the slice starting at the select byte by 2, 4 or 8 with sign or zeros
`timescale 1ns/1ns

module opq_widen import opq_pkg::*; (
  input  elen_t     word_i,
  input  opq_cmd_t  cmd_i,
  input  byte_sel_t sel_i,
  output elen_t     word_o
);

  localparam int unsigned ElenW = $bits(elen_t);

  // Source elements of w bits, packed contiguously from bit 0, each widened to w*f bits
  function automatic elen_t extend(elen_t src, int unsigned w, int unsigned f, logic sx);
    elen_t       res;
    int unsigned ow;
    int unsigned e;
    int unsigned p;
    res = '0;
    ow  = w * f;
    for (int unsigned b = 0; b < ElenW; b++) begin
      e      = b / ow;
      p      = b % ow;
      res[b] = (p < w) ? src[e*w + p] : (sx & src[e*w + w - 1]);
    end
    return res;
  endfunction

  elen_t      slice;
  logic       sign_ext;
  logic [1:0] lg_factor;

  // Natural byte order, slice starts at the select byte
  assign slice = word_i >> {sel_i, 3'b000};

  always_comb begin
    sign_ext  = 1'b0;
    lg_factor = 2'd0;
    case (cmd_i.conv)
      CONV_SEXT2: begin
        sign_ext  = 1'b1;
        lg_factor = 2'd1;
      end
      CONV_SEXT4: begin
        sign_ext  = 1'b1;
        lg_factor = 2'd2;
      end
      CONV_SEXT8: begin
        sign_ext  = 1'b1;
        lg_factor = 2'd3;
      end
      CONV_ZEXT2: lg_factor = 2'd1;
      CONV_ZEXT4: lg_factor = 2'd2;
      CONV_ZEXT8: lg_factor = 2'd3;
      default: ;
    endcase
  end

  // Unsupported width and factor pairs leave the word as it is
  always_comb begin
    word_o = word_i;
    case ({lg_factor, cmd_i.eew})
      {2'd1, EW8}:  word_o = extend(slice, 8, 2, sign_ext);
      {2'd1, EW16}: word_o = extend(slice, 16, 2, sign_ext);
      {2'd1, EW32}: word_o = extend(slice, 32, 2, sign_ext);
      {2'd2, EW8}:  word_o = extend(slice, 8, 4, sign_ext);
      {2'd2, EW16}: word_o = extend(slice, 16, 4, sign_ext);
      {2'd3, EW8}:  word_o = extend(slice, 8, 8, sign_ext);
      default: ;
    endcase
  end

endmodule
